// File: design/merge_cfg_macros.svh
// Merge engine configuration
`ifndef MERGE_CFG_MACROS_SVH
`define MERGE_CFG_MACROS_SVH

// Width of one data word on either stream
`define MERGE_DATA_W 32

// Parallel merge lanes behind the dispatcher
`define MERGE_NUM_LANES 4

// Entries per input FIFO
`define MERGE_FIFO_DEPTH 16

// Width of the descriptor item count
`define MERGE_COUNT_W 16

`endif

// File: design/merge_data_pkg.sv
// Merge data types
`default_nettype none

package merge_data_pkg;

    `include "merge_cfg_macros.svh"

    // One word from the engine or memory stream
    typedef logic [`MERGE_DATA_W-1:0] merge_word_t;

    // Combine rule applied to each engine/memory pair
    typedef enum logic [1:0] {
        MERGE_SUM      = 2'd0,
        MERGE_MIN      = 2'd1,
        MERGE_MAX      = 2'd2,
        MERGE_PASS_MEM = 2'd3
    } merge_op_e;

endpackage : merge_data_pkg

`default_nettype wire

// File: design/merge_ctrl_pkg.sv
// Merge control types
`default_nettype none

package merge_ctrl_pkg;

    `include "merge_cfg_macros.svh"

    localparam int LANE_IDX_W = (`MERGE_NUM_LANES > 1) ? $clog2(`MERGE_NUM_LANES) : 1;

    typedef enum logic {
        DISP_IDLE = 1'b0,
        DISP_RUN  = 1'b1
    } disp_state_e;

    // Round-robin lane pointer
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    typedef logic [`MERGE_COUNT_W-1:0] item_count_t;

endpackage : merge_ctrl_pkg

`default_nettype wire

// File: design/merge_sync_fifo.sv
// Synchronous stream FIFO
`timescale 1ns/1ns
`default_nettype none

module merge_sync_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic             wr_valid_i,
    output logic             wr_ready_o,
    input  logic [WIDTH-1:0] wr_data_i,
    output logic             rd_valid_o,
    input  logic             rd_ready_i,
    output logic [WIDTH-1:0] rd_data_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready_o = (count != FULL_CNT);
    assign rd_valid_o = (count != '0);
    assign rd_data_o  = mem[rd_ptr];
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (!wr_fire && rd_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // Occupancy stays within DEPTH and a full FIFO has its writer on the read entry
    a_no_write_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (count <= FULL_CNT) && ((count != FULL_CNT) || (wr_ptr == rd_ptr))
    );

endmodule : merge_sync_fifo

`default_nettype wire

// File: design/merge_lane_dispatcher.sv
// Pair dispatcher for the merge lanes
`timescale 1ns/1ns
`default_nettype none
`include "merge_cfg_macros.svh"

module merge_lane_dispatcher (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  logic                        desc_valid_i,
    output logic                        desc_ready_o,
    input  merge_data_pkg::merge_op_e   desc_op_i,
    input  merge_ctrl_pkg::item_count_t desc_count_i,
    input  logic                        eng_valid_i,
    output logic                        eng_ready_o,
    input  merge_data_pkg::merge_word_t eng_data_i,
    input  logic                        mem_valid_i,
    output logic                        mem_ready_o,
    input  merge_data_pkg::merge_word_t mem_data_i,
    output merge_data_pkg::merge_op_e   lane_op_o,
    output logic [`MERGE_NUM_LANES-1:0] lane_valid_o,
    output merge_data_pkg::merge_word_t lane_data_eng_o [`MERGE_NUM_LANES],
    output merge_data_pkg::merge_word_t lane_data_mem_o [`MERGE_NUM_LANES],
    output logic [`MERGE_NUM_LANES-1:0] lane_last_o,
    input  logic [`MERGE_NUM_LANES-1:0] lane_ready_i
);

    import merge_data_pkg::*;
    import merge_ctrl_pkg::*;

    disp_state_e state;
    item_count_t remaining;
    lane_idx_t   lane_ptr;
    merge_op_e   op_q;
    logic        desc_fire;
    logic        pair_valid;
    logic        dispatch;
    logic        is_last;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------
    assign desc_ready_o = (state == DISP_IDLE);
    assign desc_fire    = desc_valid_i && desc_ready_o;
    assign pair_valid   = (state == DISP_RUN) && eng_valid_i && mem_valid_i;
    assign dispatch     = pair_valid && lane_ready_i[lane_ptr];
    assign is_last      = (remaining == item_count_t'(1));

    // Both heads pop together and never one alone
    assign eng_ready_o = (state == DISP_RUN) && mem_valid_i && lane_ready_i[lane_ptr];
    assign mem_ready_o = (state == DISP_RUN) && eng_valid_i && lane_ready_i[lane_ptr];
    assign lane_op_o   = op_q;

    // Data fans out to every lane and only the selected one sees valid
    always_comb begin
        for (int i = 0; i < `MERGE_NUM_LANES; i++) begin
            lane_valid_o[i]    = pair_valid && (lane_ptr == lane_idx_t'(i));
            lane_data_eng_o[i] = eng_data_i;
            lane_data_mem_o[i] = mem_data_i;
            lane_last_o[i]     = is_last;
        end
    end

    // ------------------------------------------------------------
    // State, count and lane pointer
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state     <= DISP_IDLE;
            remaining <= '0;
            lane_ptr  <= '0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    // Zero-count descriptors are consumed and dropped
                    if (desc_fire && (desc_count_i != '0)) begin
                        state     <= DISP_RUN;
                        remaining <= desc_count_i;
                    end
                end
                DISP_RUN: begin
                    if (dispatch) begin
                        remaining <= remaining - 1'b1;
                        lane_ptr  <= (lane_ptr == lane_idx_t'(`MERGE_NUM_LANES - 1)) ?
                                     '0 : lane_ptr + 1'b1;
                        if (is_last) begin
                            state <= DISP_IDLE;
                        end
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (desc_fire) begin
            op_q <= desc_op_i;
        end
    end

    // A lane is only offered a pair while a run still has items left
    a_no_offer_when_idle : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (lane_valid_o != '0) |-> (state == DISP_RUN) && (remaining != '0)
    );

endmodule : merge_lane_dispatcher

`default_nettype wire

// File: design/merge_lane.sv
// Two-stage merge lane
`timescale 1ns/1ns
`default_nettype none

module merge_lane (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  merge_data_pkg::merge_op_e   op_i,
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  merge_data_pkg::merge_word_t in_eng_i,
    input  merge_data_pkg::merge_word_t in_mem_i,
    input  logic                        in_last_i,
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output merge_data_pkg::merge_word_t out_data_o,
    output logic                        out_last_o
);

    import merge_data_pkg::*;

    logic        s1_valid;
    merge_word_t s1_eng;
    merge_word_t s1_mem;
    logic        s1_last;
    merge_op_e   s1_op;
    merge_word_t s1_result;
    logic        s2_move;

    assign s2_move    = !out_valid_o || out_ready_i;
    assign in_ready_o = !s1_valid || s2_move;

    // ------------------------------------------------------------
    // Stage one captures the operands
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            s1_valid <= 1'b0;
        end else if (in_ready_o) begin
            s1_valid <= in_valid_i;
        end
    end

    // Opcode rides with the pair since a new descriptor may already be latched
    always_ff @(posedge ap_clk) begin
        if (in_ready_o && in_valid_i) begin
            s1_eng  <= in_eng_i;
            s1_mem  <= in_mem_i;
            s1_last <= in_last_i;
            s1_op   <= op_i;
        end
    end

    // ------------------------------------------------------------
    // Stage two combines and registers
    // ------------------------------------------------------------
    always_comb begin
        case (s1_op)
            MERGE_SUM:      s1_result = s1_eng + s1_mem;
            MERGE_MIN:      s1_result = (s1_eng < s1_mem) ? s1_eng : s1_mem;
            MERGE_MAX:      s1_result = (s1_eng > s1_mem) ? s1_eng : s1_mem;
            MERGE_PASS_MEM: s1_result = s1_mem;
            default:        s1_result = s1_mem;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            out_valid_o <= 1'b0;
        end else if (s2_move) begin
            out_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (s2_move && s1_valid) begin
            out_data_o <= s1_result;
            out_last_o <= s1_last;
        end
    end

    // An offered pair holds steady until stage one takes it
    a_in_stable_when_stalled : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (in_valid_i && !in_ready_o) |=>
            in_valid_i && $stable(in_eng_i) && $stable(in_mem_i) && $stable(in_last_i)
    );

endmodule : merge_lane

`default_nettype wire

// File: design/merge_lane_collector.sv
// In-order lane collector
`timescale 1ns/1ns
`default_nettype none
`include "merge_cfg_macros.svh"

module merge_lane_collector (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  logic                        desc_fire_i,
    input  logic [`MERGE_NUM_LANES-1:0] lane_valid_i,
    input  merge_data_pkg::merge_word_t lane_data_i [`MERGE_NUM_LANES],
    input  logic [`MERGE_NUM_LANES-1:0] lane_last_i,
    output logic [`MERGE_NUM_LANES-1:0] lane_ready_o,
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output merge_data_pkg::merge_word_t out_data_o,
    output logic                        done_o
);

    import merge_ctrl_pkg::*;

    lane_idx_t exp_ptr;
    logic      accept;
    logic      last_accept;

    // ------------------------------------------------------------
    // Pass-through of the expected lane
    // ------------------------------------------------------------
    assign out_valid_o = lane_valid_i[exp_ptr];
    assign out_data_o  = lane_data_i[exp_ptr];
    assign accept      = out_valid_o && out_ready_i;
    assign last_accept = accept && lane_last_i[exp_ptr];

    // Other lanes wait since their results come later in order
    always_comb begin
        lane_ready_o          = '0;
        lane_ready_o[exp_ptr] = out_ready_i;
    end

    // ------------------------------------------------------------
    // Pointer and completion flag
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            exp_ptr <= '0;
        end else if (accept) begin
            exp_ptr <= (exp_ptr == lane_idx_t'(`MERGE_NUM_LANES - 1)) ?
                       '0 : exp_ptr + 1'b1;
        end
    end

    // Last result of a run wins over a clear in the same cycle
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            done_o <= 1'b0;
        end else begin
            done_o <= (done_o && !desc_fire_i) || last_accept;
        end
    end

    // Dispatcher stops after last, so the lanes stay quiet while done
    a_quiet_when_done : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        done_o |-> !out_valid_o
    );

endmodule : merge_lane_collector

`default_nettype wire

// File: design/engine_merge_data.sv
// Merge data engine top
`timescale 1ns/1ns
`default_nettype none
`include "merge_cfg_macros.svh"

module engine_merge_data (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  logic                        desc_valid_i,
    output logic                        desc_ready_o,
    input  merge_data_pkg::merge_op_e   desc_op_i,
    input  merge_ctrl_pkg::item_count_t desc_count_i,
    input  logic                        eng_valid_i,
    output logic                        eng_ready_o,
    input  merge_data_pkg::merge_word_t eng_data_i,
    input  logic                        mem_valid_i,
    output logic                        mem_ready_o,
    input  merge_data_pkg::merge_word_t mem_data_i,
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output merge_data_pkg::merge_word_t out_data_o,
    output logic                        done_o
);

    import merge_data_pkg::*;

    logic        eng_head_valid;
    logic        eng_head_ready;
    merge_word_t eng_head_data;
    logic        mem_head_valid;
    logic        mem_head_ready;
    merge_word_t mem_head_data;
    logic        desc_fire;
    merge_op_e   lane_op;

    logic [`MERGE_NUM_LANES-1:0] lane_in_valid;
    logic [`MERGE_NUM_LANES-1:0] lane_in_ready;
    logic [`MERGE_NUM_LANES-1:0] lane_in_last;
    merge_word_t                 lane_in_data_eng [`MERGE_NUM_LANES];
    merge_word_t                 lane_in_data_mem [`MERGE_NUM_LANES];
    logic [`MERGE_NUM_LANES-1:0] lane_out_valid;
    logic [`MERGE_NUM_LANES-1:0] lane_out_ready;
    logic [`MERGE_NUM_LANES-1:0] lane_out_last;
    merge_word_t                 lane_out_data [`MERGE_NUM_LANES];

    assign desc_fire = desc_valid_i && desc_ready_o;

    // ------------------------------------------------------------
    // Input stream FIFOs
    // ------------------------------------------------------------
    merge_sync_fifo #(
        .DEPTH(`MERGE_FIFO_DEPTH),
        .WIDTH(`MERGE_DATA_W)
    ) u_eng_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_valid_i       (eng_valid_i),
        .wr_ready_o       (eng_ready_o),
        .wr_data_i        (eng_data_i),
        .rd_valid_o       (eng_head_valid),
        .rd_ready_i       (eng_head_ready),
        .rd_data_o        (eng_head_data)
    );

    merge_sync_fifo #(
        .DEPTH(`MERGE_FIFO_DEPTH),
        .WIDTH(`MERGE_DATA_W)
    ) u_mem_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_valid_i       (mem_valid_i),
        .wr_ready_o       (mem_ready_o),
        .wr_data_i        (mem_data_i),
        .rd_valid_o       (mem_head_valid),
        .rd_ready_i       (mem_head_ready),
        .rd_data_o        (mem_head_data)
    );

    // ------------------------------------------------------------
    // Dispatcher, lanes and collector
    // ------------------------------------------------------------
    merge_lane_dispatcher u_dispatcher (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .desc_valid_i     (desc_valid_i),
        .desc_ready_o     (desc_ready_o),
        .desc_op_i        (desc_op_i),
        .desc_count_i     (desc_count_i),
        .eng_valid_i      (eng_head_valid),
        .eng_ready_o      (eng_head_ready),
        .eng_data_i       (eng_head_data),
        .mem_valid_i      (mem_head_valid),
        .mem_ready_o      (mem_head_ready),
        .mem_data_i       (mem_head_data),
        .lane_op_o        (lane_op),
        .lane_valid_o     (lane_in_valid),
        .lane_data_eng_o  (lane_in_data_eng),
        .lane_data_mem_o  (lane_in_data_mem),
        .lane_last_o      (lane_in_last),
        .lane_ready_i     (lane_in_ready)
    );

    for (genvar g = 0; g < `MERGE_NUM_LANES; g++) begin : g_lane
        merge_lane u_lane (
            .ap_clk           (ap_clk),
            .areset_csr_engine(areset_csr_engine),
            .op_i             (lane_op),
            .in_valid_i       (lane_in_valid[g]),
            .in_ready_o       (lane_in_ready[g]),
            .in_eng_i         (lane_in_data_eng[g]),
            .in_mem_i         (lane_in_data_mem[g]),
            .in_last_i        (lane_in_last[g]),
            .out_valid_o      (lane_out_valid[g]),
            .out_ready_i      (lane_out_ready[g]),
            .out_data_o       (lane_out_data[g]),
            .out_last_o       (lane_out_last[g])
        );
    end

    merge_lane_collector u_collector (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .desc_fire_i      (desc_fire),
        .lane_valid_i     (lane_out_valid),
        .lane_data_i      (lane_out_data),
        .lane_last_i      (lane_out_last),
        .lane_ready_o     (lane_out_ready),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_data_o       (out_data_o),
        .done_o           (done_o)
    );

endmodule : engine_merge_data

`default_nettype wire

// File: dv/engine_merge_data_tb.sv
// Merge data engine testbench
`timescale 1ns/1ns
`default_nettype none

module engine_merge_data_tb;

    import merge_data_pkg::*;
    import merge_ctrl_pkg::*;

    // About 70 items plus stalls and skew stay well inside this
    localparam int TEST_CYCLES = 5000;
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic        ap_clk;
    logic        areset_csr_engine;
    logic        desc_valid_i;
    logic        desc_ready_o;
    merge_op_e   desc_op_i;
    item_count_t desc_count_i;
    logic        eng_valid_i;
    logic        eng_ready_o;
    merge_word_t eng_data_i;
    logic        mem_valid_i;
    logic        mem_ready_o;
    merge_word_t mem_data_i;
    logic        out_valid_o;
    logic        out_ready_i;
    merge_word_t out_data_o;
    logic        done_o;

    merge_word_t eng_words [$];
    merge_word_t mem_words [$];
    merge_word_t exp_words [$];
    int          cycle_count = 0;

    engine_merge_data DUT (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .desc_valid_i     (desc_valid_i),
        .desc_ready_o     (desc_ready_o),
        .desc_op_i        (desc_op_i),
        .desc_count_i     (desc_count_i),
        .eng_valid_i      (eng_valid_i),
        .eng_ready_o      (eng_ready_o),
        .eng_data_i       (eng_data_i),
        .mem_valid_i      (mem_valid_i),
        .mem_ready_o      (mem_ready_o),
        .mem_data_i       (mem_data_i),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_data_o       (out_data_o),
        .done_o           (done_o)
    );

    always #10 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // Reference model and compare tasks
    // ------------------------------------------------------------
    function automatic merge_word_t expected_merge(merge_op_e op, merge_word_t e, merge_word_t m);
        case (op)
            MERGE_SUM: return e + m;
            MERGE_MIN: return (e < m) ? e : m;
            MERGE_MAX: return (e > m) ? e : m;
            default:   return m;
        endcase
    endfunction

    task automatic check_word(input string name, input merge_word_t exp, input merge_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and response tasks
    // ------------------------------------------------------------
    task automatic fill_words(input merge_op_e op, input int n);
        merge_word_t e;
        merge_word_t m;
        eng_words.delete();
        mem_words.delete();
        exp_words.delete();
        for (int i = 0; i < n; i++) begin
            e = merge_word_t'($urandom);
            m = merge_word_t'($urandom);
            // First pair always wraps on a sum
            if (i == 0) begin
                e = '1;
                m = merge_word_t'(5);
            end
            eng_words.push_back(e);
            mem_words.push_back(m);
            exp_words.push_back(expected_merge(op, e, m));
        end
    endtask

    task automatic issue_desc(input merge_op_e op, input int cnt);
        @(negedge ap_clk);
        desc_valid_i = 1'b1;
        desc_op_i    = op;
        desc_count_i = item_count_t'(cnt);
        while (!desc_ready_o) @(negedge ap_clk);
        @(negedge ap_clk);
        desc_valid_i = 1'b0;
        check_flag("done_o", 1'b0, done_o);
    endtask

    task automatic send_stream(input logic to_mem, input int gap);
        repeat (gap) @(negedge ap_clk);
        for (int i = 0; i < eng_words.size(); i++) begin
            @(negedge ap_clk);
            if (to_mem) begin
                mem_valid_i = 1'b1;
                mem_data_i  = mem_words[i];
            end else begin
                eng_valid_i = 1'b1;
                eng_data_i  = eng_words[i];
            end
            while (!(to_mem ? mem_ready_o : eng_ready_o)) @(negedge ap_clk);
        end
        @(negedge ap_clk);
        if (to_mem) begin
            mem_valid_i = 1'b0;
        end else begin
            eng_valid_i = 1'b0;
        end
    endtask

    // No result and no new descriptor while the memory words lag
    task automatic watch_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge ap_clk);
            check_flag("out_valid_o", 1'b0, out_valid_o);
            check_flag("desc_ready_o", 1'b0, desc_ready_o);
        end
    endtask

    task automatic collect_results(input logic random_ready);
        int got;
        got = 0;
        while (got < exp_words.size()) begin
            @(negedge ap_clk);
            check_flag("done_o", 1'b0, done_o);
            out_ready_i = random_ready ? (($urandom % 2) == 0) : 1'b1;
            if (out_valid_o && out_ready_i) begin
                check_word("out_data_o", exp_words[got], out_data_o);
                got++;
            end
        end
        // Done is set by the edge that takes the last result
        @(negedge ap_clk);
        out_ready_i = 1'b1;
        check_flag("done_o", 1'b1, done_o);
        check_flag("out_valid_o", 1'b0, out_valid_o);
        check_flag("desc_ready_o", 1'b1, desc_ready_o);
    endtask

    task automatic run_merge(input merge_op_e op, input int cnt, input int mem_gap,
                             input logic random_ready);
        fill_words(op, cnt);
        issue_desc(op, cnt);
        fork
            send_stream(1'b0, 0);
            send_stream(1'b1, mem_gap);
            watch_quiet(mem_gap);
            collect_results(random_ready);
        join
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        @(negedge ap_clk);
        check_flag("out_valid_o", 1'b0, out_valid_o);
        check_flag("done_o", 1'b0, done_o);
        check_flag("desc_ready_o", 1'b1, desc_ready_o);
        check_flag("eng_ready_o", 1'b1, eng_ready_o);
        check_flag("mem_ready_o", 1'b1, mem_ready_o);
    endtask

    task automatic test_sum_wrap();
        run_merge(MERGE_SUM, 12, 0, 1'b0);
    endtask

    task automatic test_min_max_pass();
        run_merge(MERGE_MIN, 8, 0, 1'b0);
        run_merge(MERGE_MAX, 8, 0, 1'b0);
        run_merge(MERGE_PASS_MEM, 8, 0, 1'b0);
    endtask

    task automatic test_backpressure();
        run_merge(MERGE_SUM, 20, 0, 1'b1);
    endtask

    task automatic test_skew_and_done();
        run_merge(MERGE_MAX, 8, 30, 1'b0);
        repeat (3) begin
            @(negedge ap_clk);
            check_flag("done_o", 1'b1, done_o);
        end
        // Empty descriptor still clears done
        issue_desc(MERGE_SUM, 0);
        check_flag("desc_ready_o", 1'b1, desc_ready_o);
        check_flag("out_valid_o", 1'b0, out_valid_o);
        run_merge(MERGE_PASS_MEM, 4, 0, 1'b0);
    endtask

    initial begin
        void'($urandom(326));
        ap_clk            = 1'b0;
        areset_csr_engine = 1'b1;
        desc_valid_i      = 1'b0;
        desc_op_i         = MERGE_SUM;
        desc_count_i      = '0;
        eng_valid_i       = 1'b0;
        eng_data_i        = '0;
        mem_valid_i       = 1'b0;
        mem_data_i        = '0;
        out_ready_i       = 1'b1;
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_engine = 1'b0;

        test_reset_state();
        test_sum_wrap();
        test_min_max_pass();
        test_backpressure();
        test_skew_and_done();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : engine_merge_data_tb

`default_nettype wire

// File: project.f
+incdir+design
design/merge_data_pkg.sv
design/merge_ctrl_pkg.sv
design/merge_sync_fifo.sv
design/merge_lane_dispatcher.sv
design/merge_lane.sv
design/merge_lane_collector.sv
design/engine_merge_data.sv
dv/engine_merge_data_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module engine_merge_data_tb -o engine_merge_data_sim

output=$(./obj_dir/engine_merge_data_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
